// ==== build.f ====
lsu_cfg_pkg.sv
lsu_haz_pkg.sv
replay_head_if.sv
replay_entry_ring.sv
replay_pace_timer.sv
replay_release_ctrl.sv
lsu_replay_top.sv
lsu_replay_chk.sv
lsu_replay_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lsu_replay_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== lsu_replay_tb.sv ====
// replay queue testbench; expects REPLAY_DEPTH 4 and TIMER_W 4, requests sampled on the falling edge
module lsu_replay_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import lsu_cfg_pkg::*;
  import lsu_haz_pkg::*;

  localparam int DEPTH = 4;
  localparam int WAIT_LIMIT = 40;
  localparam int CLK_PERIOD = 100;

  typedef enum int {RES_NONE, RES_STQ, RES_RMW, RES_MFULL, RES_MRES} res_e;

  typedef struct {
    string    name;
    haz_typ_e typ;
    logic [7:0] index;
    res_e     res;
    int       hold;
    bit       flush;
    int       count;
    bit       ready;
    int       space;
  } row_t;

  typedef struct {
    logic [4:0]  cmt;
    logic [3:0]  grp;
    logic [2:0]  typ;
    logic [7:0]  index;
    logic [15:0] payload;
  } exp_t;

  logic i_clk, i_reset_n, i_haz_valid, i_flush, i_req_ready;
  cmt_id_t i_haz_cmt_id, i_rob_head_cmt_id, o_req_cmt_id;
  grp_id_t i_haz_grp_id, i_rob_done_grp, o_req_grp_id;
  haz_typ_e i_haz_typ, o_req_typ;
  haz_index_u i_haz_index, o_req_index;
  logic [PAYLOAD_W-1:0] i_haz_payload, o_req_payload;
  logic o_full, o_req_valid, i_stbuf_empty, i_missu_full, i_missu_empty, i_missu_resolve_valid;
  logic [MISSU_SIZE-1:0] i_missu_resolve_oh, i_missu_entry_valids;
  logic [STQ_SIZE-1:0] i_stq_resolve_oh;

  exp_t  model[$];
  time   req_at[$];
  exp_t  last_e;
  row_t  rows [10];
  string cur_name;
  int    errors;
  int    n_reqs;

  lsu_replay_top #(.REPLAY_DEPTH(DEPTH), .TIMER_W(4)) uut (.*);

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  task automatic check_val(string what, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("** Error: %s %s expected %h actual %h", cur_name, what, exp, act);
    end
  endtask

  task automatic fail_msg(string what);
    errors++;
    $display("%s: %s", cur_name, what);
  endtask

  // --------------------
  // scoreboard
  // --------------------

  always @(negedge i_clk) begin
    exp_t e;
    if (i_reset_n && o_req_valid && i_req_ready) begin
      if (model.size() == 0) begin
        fail_msg("request seen with no live entry queued");
      end else begin
        e = model.pop_front();
        check_val("cmt_id", 32'(e.cmt), 32'(o_req_cmt_id));
        check_val("grp_id", 32'(e.grp), 32'(o_req_grp_id));
        check_val("typ", 32'(e.typ), 32'(o_req_typ));
        check_val("index", 32'(e.index), 32'(o_req_index));
        check_val("payload", 32'(e.payload), 32'(o_req_payload));
      end
      req_at.push_back($time);
      n_reqs++;
    end
  end

  task automatic wait_reqs(int target);
    int n;
    n = 0;
    while (n_reqs < target && n < WAIT_LIMIT) begin
      @(posedge i_clk);
      n++;
    end
    if (n_reqs < target) begin
      fail_msg("timed out waiting for a request");
    end
  endtask

  task automatic push_entry(row_t r, int k);
    exp_t e;
    e.cmt     = 5'($urandom);
    e.grp     = 4'(1 << (k % 4));
    e.typ     = r.typ;
    e.index   = r.index;
    e.payload = 16'($urandom);
    @(negedge i_clk);
    if (o_full) begin
      fail_msg("queue full before a push");
    end
    @(posedge i_clk);
    i_haz_valid   <= 1'b1;
    i_haz_cmt_id  <= e.cmt;
    i_haz_grp_id  <= e.grp;
    i_haz_typ     <= r.typ;
    i_haz_index   <= r.index;
    i_haz_payload <= e.payload;
    model.push_back(e);
    last_e = e;
    @(posedge i_clk);
    i_haz_valid <= 1'b0;
  endtask

  // idle values keep every hazard rule false
  task automatic clear_resolve();
    i_rob_head_cmt_id     <= '0;
    i_rob_done_grp        <= '0;
    i_stbuf_empty         <= 1'b0;
    i_missu_full          <= 1'b1;
    i_missu_empty         <= 1'b0;
    i_missu_resolve_valid <= 1'b0;
    i_missu_resolve_oh    <= '0;
    i_missu_entry_valids  <= '1;
    i_stq_resolve_oh      <= '0;
  endtask

  task automatic apply_resolve(row_t r);
    case (r.res)
      RES_STQ:   i_stq_resolve_oh <= r.index;
      RES_RMW: begin
        i_rob_head_cmt_id <= last_e.cmt;
        i_rob_done_grp    <= '1;
        i_stbuf_empty     <= 1'b1;
        i_missu_empty     <= 1'b1;
      end
      RES_MFULL: i_missu_full <= 1'b0;
      RES_MRES: begin
        i_missu_resolve_valid <= 1'b1;
        i_missu_resolve_oh    <= r.index[MISSU_SIZE-1:0];
      end
      default: ;
    endcase
  endtask

  // --------------------
  // one table row
  // --------------------

  task automatic run_row(row_t r);
    int base;
    logic [15:0] held;
    cur_name = r.name;
    @(posedge i_clk);
    i_req_ready <= r.ready;
    base = n_reqs;
    for (int k = 0; k < r.count; k++) begin
      push_entry(r, k);
      // push_entry itself takes two cycles
      if (r.space > 2) begin
        repeat (r.space - 2) @(posedge i_clk);
      end
    end
    if (!r.ready && !r.flush) begin
      @(negedge i_clk);
      check_val("o_full", 32'(r.count == DEPTH), 32'(o_full));
      held = model[0].payload;
      repeat (4) begin
        @(negedge i_clk);
        check_val("held valid", 32'd1, 32'(o_req_valid));
        check_val("held payload", 32'(held), 32'(o_req_payload));
      end
      @(posedge i_clk);
      i_req_ready <= 1'b1;
      wait_reqs(base + r.count);
    end else if (r.flush) begin
      @(posedge i_clk);
      i_flush <= 1'b1;
      model.delete();
      @(posedge i_clk);
      i_flush     <= 1'b0;
      i_req_ready <= 1'b1;
      repeat (6) begin
        @(negedge i_clk);
        if (o_req_valid) fail_msg("flushed entry produced a request");
      end
      base = n_reqs;
      push_entry(r, 0);
      wait_reqs(base + 1);
    end else begin
      repeat (r.hold) begin
        @(negedge i_clk);
        if (o_req_valid) fail_msg("released before its hazard cleared");
      end
      @(posedge i_clk);
      apply_resolve(r);
      for (int k = 1; k <= r.count; k++) wait_reqs(base + k);
      // a paced entry leaves its push spacing after the pop ahead of it
      if (r.space > 0 && req_at.size() >= base + 2) begin
        check_val("pace cycles", 32'(r.space),
                  32'((req_at[base + 1] - req_at[base]) / CLK_PERIOD));
      end
      @(posedge i_clk);
      clear_resolve();
    end
    @(negedge i_clk);
    check_val("o_full after drain", 32'd0, 32'(o_full));
  endtask

  initial begin
    void'($urandom(32'h7e61_b636));
    i_clk = 1'b0;
    i_reset_n = 1'b0;
    i_haz_valid = 1'b0;
    i_haz_cmt_id = '0;
    i_haz_grp_id = '0;
    i_haz_typ = HAZ_L1D_CONFLICT;
    i_haz_index = '0;
    i_haz_payload = '0;
    i_flush = 1'b0;
    i_req_ready = 1'b0;
    i_rob_head_cmt_id = '0;
    i_rob_done_grp = '0;
    i_stbuf_empty = 1'b0;
    i_missu_full = 1'b1;
    i_missu_empty = 1'b0;
    i_missu_resolve_valid = 1'b0;
    i_missu_resolve_oh = '0;
    i_missu_entry_valids = '1;
    i_stq_resolve_oh = '0;
    errors = 0;
    n_reqs = 0;
    cur_name = "reset";
    // name, type, index, resolve, hold, flush, count, ready, push spacing
    rows[0] = '{"in_order", HAZ_L1D_CONFLICT, 8'h01, RES_NONE, 0, 0, 4, 1, 0};
    rows[1] = '{"back_pressure", HAZ_L1D_CONFLICT, 8'h02, RES_NONE, 0, 0, DEPTH, 0, 0};
    rows[2] = '{"stq_nonfwd", HAZ_STQ_NONFWD, 8'h24, RES_STQ, 8, 0, 1, 1, 0};
    rows[3] = '{"rmw_order", HAZ_RMW_ORDER, 8'h00, RES_RMW, 8, 0, 1, 1, 0};
    rows[4] = '{"missu_full", HAZ_MISSU_FULL, 8'h00, RES_MFULL, 8, 0, 1, 1, 0};
    rows[5] = '{"missu_assigned", HAZ_MISSU_ASSIGNED, 8'h04, RES_MRES, 8, 0, 1, 1, 0};
    rows[6] = '{"timeout", HAZ_MISSU_FULL, 8'h00, RES_NONE, 8, 0, 1, 1, 0};
    rows[7] = '{"flush", HAZ_L1D_CONFLICT, 8'h08, RES_NONE, 0, 1, 3, 0, 0};
    rows[8] = '{"pacing", HAZ_MISSU_FULL, 8'h00, RES_NONE, 0, 0, 2, 1, 3};
    rows[9] = '{"in_order_again", HAZ_L1D_CONFLICT, 8'h10, RES_NONE, 0, 0, 4, 1, 0};
    repeat (16) @(posedge i_clk);
    i_reset_n <= 1'b1;
    @(negedge i_clk);
    check_val("o_full after reset", 32'd0, 32'(o_full));
    check_val("o_req_valid after reset", 32'd0, 32'(o_req_valid));
    foreach (rows[i]) run_row(rows[i]);
    $display("checks done: %0d errors, %0d requests", errors, n_reqs);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== lsu_replay_chk.sv ====
// bound protocol checks on the replay top; assumes the default five hazard codes and active low reset
module lsu_replay_chk (
  input logic                              i_clk,
  input logic                              i_reset_n,
  input logic                              i_haz_valid,
  input logic                              i_full,
  input logic                              i_empty,
  input logic                              i_req_valid,
  input logic                              i_req_ready,
  input lsu_haz_pkg::haz_typ_e             i_req_typ,
  input logic [lsu_cfg_pkg::PAYLOAD_W-1:0] i_req_payload
);
  timeunit 1ns;
  timeprecision 100ps;
  import lsu_haz_pkg::*;

  // producer must respect full
  a_no_push_when_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_haz_valid && i_full)) else $error("push while the queue is full");

  a_no_req_when_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_req_valid && i_empty)) else $error("request from an empty queue");

  // head type must be one of the known codes
  a_known_head_typ: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !i_empty |-> (i_req_typ <= HAZ_MISSU_ASSIGNED)) else $error("unknown hazard type at head");

  a_payload_held: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_req_valid && !i_req_ready) |=> $stable(i_req_payload)) else $error("payload moved under stall");

endmodule

bind lsu_replay_top lsu_replay_chk u_chk (
  .i_clk(i_clk), .i_reset_n(i_reset_n), .i_haz_valid(i_haz_valid), .i_full(o_full),
  .i_empty(w_empty), .i_req_valid(o_req_valid), .i_req_ready(i_req_ready),
  .i_req_typ(o_req_typ), .i_req_payload(o_req_payload)
);

// ==== lsu_replay_top.sv ====
// replay queue top; i_haz_valid must stay low while o_full is high, o_req_* valid with o_req_valid
module lsu_replay_top #(
  parameter int REPLAY_DEPTH = 4,
  parameter int TIMER_W      = 4
) (
  input  logic                                 i_clk,
  input  logic                                 i_reset_n,
  input  logic                                 i_haz_valid,
  input  lsu_cfg_pkg::cmt_id_t                 i_haz_cmt_id,
  input  lsu_cfg_pkg::grp_id_t                 i_haz_grp_id,
  input  lsu_haz_pkg::haz_typ_e                i_haz_typ,
  input  lsu_haz_pkg::haz_index_u              i_haz_index,
  input  logic [lsu_cfg_pkg::PAYLOAD_W-1:0]    i_haz_payload,
  output logic                                 o_full,
  input  logic                                 i_flush,
  input  lsu_cfg_pkg::cmt_id_t                 i_rob_head_cmt_id,
  input  lsu_cfg_pkg::grp_id_t                 i_rob_done_grp,
  input  logic                                 i_stbuf_empty,
  input  logic                                 i_missu_full,
  input  logic                                 i_missu_empty,
  input  logic                                 i_missu_resolve_valid,
  input  logic [lsu_cfg_pkg::MISSU_SIZE-1:0]   i_missu_resolve_oh,
  input  logic [lsu_cfg_pkg::MISSU_SIZE-1:0]   i_missu_entry_valids,
  input  logic [lsu_cfg_pkg::STQ_SIZE-1:0]     i_stq_resolve_oh,
  input  logic                                 i_req_ready,
  output logic                                 o_req_valid,
  output lsu_cfg_pkg::cmt_id_t                 o_req_cmt_id,
  output lsu_cfg_pkg::grp_id_t                 o_req_grp_id,
  output lsu_haz_pkg::haz_typ_e                o_req_typ,
  output lsu_haz_pkg::haz_index_u              o_req_index,
  output logic [lsu_cfg_pkg::PAYLOAD_W-1:0]    o_req_payload
);
  import lsu_haz_pkg::*;

  replay_entry_t      w_haz_entry;
  replay_entry_t      w_req_entry;
  logic               w_pop;
  logic               w_push;
  logic               w_empty;
  logic [TIMER_W-1:0] w_push_gap;
  logic [TIMER_W-1:0] w_since_pop;
  logic               w_timed_out;

  replay_head_if #(.TIMER_W(TIMER_W)) head_if ();

  // pack the access on the way in, unpack on the way out
  assign w_haz_entry.typ     = i_haz_typ;
  assign w_haz_entry.index   = i_haz_index;
  assign w_haz_entry.payload = i_haz_payload;
  assign o_req_typ     = w_req_entry.typ;
  assign o_req_index   = w_req_entry.index;
  assign o_req_payload = w_req_entry.payload;

  // --------------------
  // blocks
  // --------------------

  replay_entry_ring #(.REPLAY_DEPTH(REPLAY_DEPTH), .TIMER_W(TIMER_W)) u_ring (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_haz_valid(i_haz_valid), .i_haz_cmt_id(i_haz_cmt_id),
    .i_haz_grp_id(i_haz_grp_id), .i_haz_entry(w_haz_entry),
    .i_flush(i_flush), .i_pop(w_pop), .i_push_gap(w_push_gap),
    .o_full(o_full), .o_push(w_push), .o_empty(w_empty), .head(head_if.ring)
  );

  replay_pace_timer #(.TIMER_W(TIMER_W)) u_timer (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_push(w_push), .i_empty(w_empty), .i_pop(w_pop),
    .o_push_gap(w_push_gap), .o_since_pop(w_since_pop), .o_timed_out(w_timed_out)
  );

  replay_release_ctrl #(.TIMER_W(TIMER_W)) u_ctrl (
    .head(head_if.ctrl), .i_since_pop(w_since_pop), .i_timed_out(w_timed_out),
    .i_rob_head_cmt_id(i_rob_head_cmt_id), .i_rob_done_grp(i_rob_done_grp),
    .i_stbuf_empty(i_stbuf_empty), .i_missu_full(i_missu_full),
    .i_missu_empty(i_missu_empty), .i_missu_resolve_valid(i_missu_resolve_valid),
    .i_missu_resolve_oh(i_missu_resolve_oh), .i_missu_entry_valids(i_missu_entry_valids),
    .i_stq_resolve_oh(i_stq_resolve_oh), .i_req_ready(i_req_ready),
    .o_pop(w_pop), .o_req_valid(o_req_valid), .o_req_cmt_id(o_req_cmt_id),
    .o_req_grp_id(o_req_grp_id), .o_req_entry(w_req_entry)
  );

endmodule

// ==== replay_release_ctrl.sv ====
// release decision is purely combinational; grp ids must be one-hot for the oldest check
module replay_release_ctrl #(
  parameter int TIMER_W = 4
) (
  replay_head_if.ctrl                           head,
  input  logic [TIMER_W-1:0]                    i_since_pop,
  input  logic                                  i_timed_out,
  input  lsu_cfg_pkg::cmt_id_t                  i_rob_head_cmt_id,
  input  lsu_cfg_pkg::grp_id_t                  i_rob_done_grp,
  input  logic                                  i_stbuf_empty,
  input  logic                                  i_missu_full,
  input  logic                                  i_missu_empty,
  input  logic                                  i_missu_resolve_valid,
  input  logic [lsu_cfg_pkg::MISSU_SIZE-1:0]    i_missu_resolve_oh,
  input  logic [lsu_cfg_pkg::MISSU_SIZE-1:0]    i_missu_entry_valids,
  input  logic [lsu_cfg_pkg::STQ_SIZE-1:0]      i_stq_resolve_oh,
  input  logic                                  i_req_ready,
  output logic                                  o_pop,
  output logic                                  o_req_valid,
  output lsu_cfg_pkg::cmt_id_t                  o_req_cmt_id,
  output lsu_cfg_pkg::grp_id_t                  o_req_grp_id,
  output lsu_haz_pkg::replay_entry_t            o_req_entry
);
  import lsu_cfg_pkg::*;
  import lsu_haz_pkg::*;

  grp_id_t                 w_below_mask;
  logic                    w_head_oldest;
  logic                    w_pace_release;
  logic                    w_haz_release;
  logic                    w_release;
  logic [MISSU_SIZE-1:0]   w_missu_oh;

  // one-hot minus one gives every older slot of the block
  assign w_below_mask  = head.head_grp_id - 1'b1;
  assign w_head_oldest = (i_rob_head_cmt_id == head.head_cmt_id) &&
                         ((i_rob_done_grp & w_below_mask) == w_below_mask);
  assign w_missu_oh    = head.head_entry.index.missu.missu_oh;

  // replay at the spacing of arrival, or after a full timeout
  assign w_pace_release = ((head.head_gap != '0) && (i_since_pop == head.head_gap)) ||
                          ((head.head_gap == '0) && i_timed_out);

  // --------------------
  // hazard rules
  // --------------------

  always_comb begin
    case (head.head_entry.typ)
      HAZ_STQ_NONFWD:     w_haz_release = (head.head_entry.index.stq_oh & ~i_stq_resolve_oh) == '0;
      HAZ_RMW_ORDER:      w_haz_release = w_head_oldest & i_stbuf_empty & i_missu_empty;
      HAZ_L1D_CONFLICT:   w_haz_release = 1'b1;
      HAZ_MISSU_FULL:     w_haz_release = ~i_missu_full;
      // resolved, or the miss entry went away
      HAZ_MISSU_ASSIGNED: w_haz_release = (i_missu_resolve_valid &&
                                           (i_missu_resolve_oh == w_missu_oh)) ||
                                          ((w_missu_oh & i_missu_entry_valids) == '0);
      default:            w_haz_release = 1'b0;
    endcase
  end

  // dead heads leave without a request
  assign w_release   = head.head_valid &
                       (head.head_dead | w_pace_release | w_haz_release);
  assign o_req_valid = w_release & ~head.head_dead;
  assign o_pop       = w_release & (i_req_ready | head.head_dead);

  assign o_req_cmt_id = head.head_cmt_id;
  assign o_req_grp_id = head.head_grp_id;
  assign o_req_entry  = head.head_entry;

endmodule

// ==== replay_pace_timer.sv ====
// pacing counters saturate at all ones, so spacings of 2**TIMER_W-1 cycles or more look equal
module replay_pace_timer #(
  parameter int TIMER_W = 4
) (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_push,
  input  logic               i_empty,
  input  logic               i_pop,
  output logic [TIMER_W-1:0] o_push_gap,
  output logic [TIMER_W-1:0] o_since_pop,
  output logic               o_timed_out
);

  logic [TIMER_W-1:0] r_push_gap;
  logic [TIMER_W-1:0] r_since_pop;

  // cycles since the previous push, restarted while nothing is queued
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_push_gap <= '0;
    end else if (i_empty || i_push) begin
      r_push_gap <= TIMER_W'(1);
    end else if (!(&r_push_gap)) begin
      r_push_gap <= r_push_gap + 1'b1;
    end
  end

  // cycles since the last pop
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_since_pop <= '0;
    end else if (i_pop) begin
      r_since_pop <= TIMER_W'(1);
    end else if (!(&r_since_pop)) begin
      r_since_pop <= r_since_pop + 1'b1;
    end
  end

  // first entry of a burst has no predecessor to pace against
  assign o_push_gap  = i_empty ? '0 : r_push_gap;
  assign o_since_pop = r_since_pop;
  assign o_timed_out = &r_since_pop;

endmodule

// ==== replay_entry_ring.sv ====
// in-order entry storage; a push while o_full is high is dropped, i_pop only while the head is valid
module replay_entry_ring #(
  parameter int REPLAY_DEPTH = 4,
  parameter int TIMER_W      = 4
) (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  logic                       i_haz_valid,
  input  lsu_cfg_pkg::cmt_id_t       i_haz_cmt_id,
  input  lsu_cfg_pkg::grp_id_t       i_haz_grp_id,
  input  lsu_haz_pkg::replay_entry_t i_haz_entry,
  input  logic                       i_flush,
  input  logic                       i_pop,
  input  logic [TIMER_W-1:0]         i_push_gap,
  output logic                       o_full,
  output logic                       o_push,
  output logic                       o_empty,
  replay_head_if.ring                head
);
  import lsu_cfg_pkg::*;
  import lsu_haz_pkg::*;

  localparam int PTR_W = (REPLAY_DEPTH > 1) ? $clog2(REPLAY_DEPTH) : 1;

  // pointer advance with wrap at the last slot
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(REPLAY_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  logic [PTR_W-1:0]        r_wr_ptr;
  logic [PTR_W-1:0]        r_rd_ptr;
  logic [REPLAY_DEPTH-1:0] r_valid;
  logic [REPLAY_DEPTH-1:0] r_dead;
  cmt_id_t                 r_cmt_id [REPLAY_DEPTH];
  grp_id_t                 r_grp_id [REPLAY_DEPTH];
  replay_entry_t           r_entry  [REPLAY_DEPTH];
  logic [TIMER_W-1:0]      r_gap    [REPLAY_DEPTH];
  logic                    w_push;

  // a valid slot under the write pointer means every slot is taken
  assign o_full  = r_valid[r_wr_ptr];
  assign o_empty = ~r_valid[r_rd_ptr];
  assign w_push  = i_haz_valid & ~o_full;
  assign o_push  = w_push;

  // --------------------
  // pointers
  // --------------------

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
    end else begin
      if (w_push) begin
        r_wr_ptr <= ptr_next(r_wr_ptr);
      end
      if (i_pop) begin
        r_rd_ptr <= ptr_next(r_rd_ptr);
      end
    end
  end

  // --------------------
  // slot tags
  // --------------------

  // a new entry is live even when a flush lands on the same edge
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
      r_dead  <= '0;
    end else begin
      for (int i = 0; i < REPLAY_DEPTH; i++) begin
        if (w_push && (r_wr_ptr == PTR_W'(i))) begin
          r_valid[i] <= 1'b1;
          r_dead[i]  <= 1'b0;
        end else if (i_pop && (r_rd_ptr == PTR_W'(i))) begin
          r_valid[i] <= 1'b0;
        end else if (i_flush && r_valid[i]) begin
          r_dead[i] <= 1'b1;
        end
      end
    end
  end

  // payload slots
  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_cmt_id[r_wr_ptr] <= i_haz_cmt_id;
      r_grp_id[r_wr_ptr] <= i_haz_grp_id;
      r_entry[r_wr_ptr]  <= i_haz_entry;
      r_gap[r_wr_ptr]    <= i_push_gap;
    end
  end

  // head view for the release side
  assign head.head_valid  = r_valid[r_rd_ptr];
  assign head.head_dead   = r_dead[r_rd_ptr];
  assign head.head_cmt_id = r_cmt_id[r_rd_ptr];
  assign head.head_grp_id = r_grp_id[r_rd_ptr];
  assign head.head_entry  = r_entry[r_rd_ptr];
  assign head.head_gap    = r_gap[r_rd_ptr];

endmodule

// ==== replay_head_if.sv ====
// head of the replay queue; contents are held stable until the head is popped
interface replay_head_if #(
  parameter int TIMER_W = 4
);

  // queue not empty
  logic                       head_valid;

  // flushed, to be dropped without a request
  logic                       head_dead;

  // age of the access in the reorder buffer
  lsu_cfg_pkg::cmt_id_t       head_cmt_id;
  lsu_cfg_pkg::grp_id_t       head_grp_id;

  lsu_haz_pkg::replay_entry_t head_entry;

  // push spacing recorded for this entry, 0 when pushed into an empty queue
  logic [TIMER_W-1:0]         head_gap;

  modport ring (
    output head_valid, head_dead, head_cmt_id, head_grp_id, head_entry, head_gap
  );

  modport ctrl (
    input head_valid, head_dead, head_cmt_id, head_grp_id, head_entry, head_gap
  );

endinterface

// ==== lsu_haz_pkg.sv ====
// hazard encodings of a parked access; the index word is only meaningful together with the type
package lsu_haz_pkg;

  // --------------------
  // hazard type
  // --------------------

  // codes 5 to 7 are unused and never released by rule
  typedef enum logic [2:0] {
    HAZ_STQ_NONFWD     = 3'd0,
    HAZ_RMW_ORDER      = 3'd1,
    HAZ_L1D_CONFLICT   = 3'd2,
    HAZ_MISSU_FULL     = 3'd3,
    HAZ_MISSU_ASSIGNED = 3'd4
  } haz_typ_e;

  // --------------------
  // hazard index
  // --------------------

  // miss unit reading, right aligned in the index word
  typedef struct packed {
    logic [lsu_cfg_pkg::STQ_SIZE-lsu_cfg_pkg::MISSU_SIZE-1:0] pad;
    logic [lsu_cfg_pkg::MISSU_SIZE-1:0]                       missu_oh;
  } missu_index_t;

  // store queue one-hot or miss unit one-hot, picked by the type
  typedef union packed {
    logic [lsu_cfg_pkg::STQ_SIZE-1:0] stq_oh;
    missu_index_t                     missu;
  } haz_index_u;

  // one parked access, 27 bits with the default sizes
  typedef struct packed {
    haz_typ_e                          typ;
    haz_index_u                        index;
    logic [lsu_cfg_pkg::PAYLOAD_W-1:0] payload;
  } replay_entry_t;

endpackage

// ==== lsu_cfg_pkg.sv ====
// sizes of the surrounding LSU; grp ids are one-hot, the miss unit must be smaller than the store queue
package lsu_cfg_pkg;

  // --------------------
  // reorder buffer ids
  // --------------------

  localparam int CMT_ID_W = 5;
  typedef logic [CMT_ID_W-1:0] cmt_id_t;

  // one bit per slot of a commit block
  localparam int GRP_W = 4;
  typedef logic [GRP_W-1:0] grp_id_t;

  // --------------------
  // hazard sources
  // --------------------

  // store queue entries
  localparam int STQ_SIZE = 8;

  // miss unit entries, fewer than the store queue
  localparam int MISSU_SIZE = 4;

  // --------------------
  // access payload
  // --------------------

  // opaque tag handed back to the pipeline on replay
  localparam int PAYLOAD_W = 16;

endpackage
